/* design/memstage_pkg.sv */
`default_nettype none

package memstage_pkg;

    // ========================================================================
    // Basic data types.
    // ========================================================================
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byteen_t;
    typedef logic [4:0]  cache_code_t;

    // Unsigned loads share the signed opcodes.
    typedef enum logic [3:0] {
        OP_LB    = 4'd0,
        OP_LH    = 4'd1,
        OP_LW    = 4'd2,
        OP_LL    = 4'd3,
        OP_SB    = 4'd4,
        OP_SH    = 4'd5,
        OP_SW    = 4'd6,
        OP_SC    = 4'd7,
        OP_CACHE = 4'd8
    } mem_op_e;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } size_e;

    typedef enum logic [1:0] {
        CACHE_NONE             = 2'd0,
        CACHE_INDEX_INVALIDATE = 2'd1,
        CACHE_STORE_TAG        = 2'd2,
        CACHE_HIT_WRITEBACK    = 2'd3
    } cache_op_e;

    // ========================================================================
    // Decode constants.
    // ========================================================================
    // Operation select in cache code bits [4:2].
    localparam logic [2:0] CACHE_SEL_INDEX_INVALIDATE = 3'b000;
    localparam logic [2:0] CACHE_SEL_STORE_TAG        = 3'b010;

    // Target select in cache code bits [1:0].
    localparam logic [1:0] CACHE_TARGET_ICACHE = 2'b00;
    localparam logic [1:0] CACHE_TARGET_DCACHE = 2'b01;

    localparam byteen_t BYTEEN_NONE      = 4'b0000;
    localparam byteen_t BYTEEN_LANE0     = 4'b0001;
    localparam byteen_t BYTEEN_LOW_HALF  = 4'b0011;
    localparam byteen_t BYTEEN_HIGH_HALF = 4'b1100;
    localparam byteen_t BYTEEN_ALL       = 4'b1111;

    localparam word_t WORD_ZERO = 32'h0000_0000;

endpackage

`default_nettype wire

/* design/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded request from the decoder to the router.
interface mem_req_if;

    logic                     valid;
    memstage_pkg::mem_op_e     op;
    memstage_pkg::word_t       addr;
    memstage_pkg::word_t       wdata;
    memstage_pkg::byteen_t     byteen;
    memstage_pkg::size_e       size;
    logic                     uncached;
    logic                     misaligned;
    memstage_pkg::cache_code_t cache_code;

    modport src (
        output valid, op, addr, wdata, byteen, size, uncached, misaligned, cache_code
    );

    modport dst (
        input valid, op, addr, wdata, byteen, size, uncached, misaligned, cache_code
    );

endinterface

`default_nettype wire

/* design/bus_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Routed command from the router to the store aligner.
interface bus_cmd_if;

    logic                   cached_rd;
    logic                   cached_wr;
    logic                   uncached_rd;
    logic                   uncached_wr;
    memstage_pkg::cache_op_e icache_op;
    memstage_pkg::cache_op_e dcache_op;
    memstage_pkg::word_t     addr;
    memstage_pkg::byteen_t   byteen;
    memstage_pkg::size_e     size;
    memstage_pkg::word_t     wdata;
    logic                   addr_error;

    modport src (
        output cached_rd, cached_wr, uncached_rd, uncached_wr,
        output icache_op, dcache_op, addr, byteen, size, wdata, addr_error
    );

    modport dst (
        input cached_rd, cached_wr, uncached_rd, uncached_wr,
        input icache_op, dcache_op, addr, byteen, size, wdata, addr_error
    );

endinterface

`default_nettype wire

/* design/reset_stretcher.sv */
`timescale 1ns/1ps
`default_nettype none

module reset_stretcher #(
    parameter int RESET_COUNT_WIDTH = 7
) (
    input  logic i_clk,
    input  logic i_myreset,
    output logic o_int_reset,
    output logic o_ready
);

    logic [RESET_COUNT_WIDTH-1:0] count;
    logic                         ready;

    // Counts only between reset release and saturation.
    always_ff @(posedge i_clk) begin
        if (i_myreset) begin
            count <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            count <= count + 1'b1;
            if (&count) begin
                ready <= 1'b1;
            end
        end
    end

    assign o_int_reset = i_myreset | ~ready;
    assign o_ready     = ready;

endmodule

`default_nettype wire

/* design/mem_op_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_op_decoder (
    input  logic                      Clk,
    input  logic                      i_int_reset,
    input  logic                      i_valid,
    input  memstage_pkg::mem_op_e     i_op,
    input  memstage_pkg::word_t       i_addr,
    input  memstage_pkg::word_t       i_wdata,
    input  logic                      i_uncached,
    input  logic                      i_except,
    input  memstage_pkg::cache_code_t i_cache_code,
    mem_req_if.src                    req
);

    logic                  accept;
    memstage_pkg::size_e   size_d;
    memstage_pkg::byteen_t byteen_d;
    logic                  misaligned_d;

    // Pending exception kills the request here.
    assign accept = i_valid & ~i_except;

    // ========================================================================
    // Size, lane and alignment decode.
    // ========================================================================
    always_comb begin
        size_d       = memstage_pkg::SIZE_WORD;
        byteen_d     = memstage_pkg::BYTEEN_ALL;
        misaligned_d = 1'b0;
        case (i_op)
            memstage_pkg::OP_LB, memstage_pkg::OP_SB: begin
                size_d   = memstage_pkg::SIZE_BYTE;
                byteen_d = memstage_pkg::BYTEEN_LANE0 << i_addr[1:0];
            end
            memstage_pkg::OP_LH, memstage_pkg::OP_SH: begin
                size_d       = memstage_pkg::SIZE_HALF;
                byteen_d     = i_addr[1] ? memstage_pkg::BYTEEN_HIGH_HALF
                                         : memstage_pkg::BYTEEN_LOW_HALF;
                misaligned_d = i_addr[0];
            end
            memstage_pkg::OP_CACHE: begin
                byteen_d = memstage_pkg::BYTEEN_NONE;
            end
            default: begin
                misaligned_d = |i_addr[1:0];
            end
        endcase
        // No lanes for a faulting access.
        if (misaligned_d) begin
            byteen_d = memstage_pkg::BYTEEN_NONE;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_int_reset) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept;
        end
    end

    always_ff @(posedge Clk) begin
        req.op         <= i_op;
        req.addr       <= i_addr;
        req.wdata      <= i_wdata;
        req.byteen     <= byteen_d;
        req.size       <= size_d;
        req.uncached   <= i_uncached;
        req.misaligned <= misaligned_d;
        req.cache_code <= i_cache_code;
    end

    // A valid CACHE request never carries lanes.
    a_cache_no_byteen: assert property (
        @(posedge Clk) disable iff (i_int_reset)
        (req.valid && req.op == memstage_pkg::OP_CACHE)
            |-> (req.byteen == memstage_pkg::BYTEEN_NONE)
    ) else $error("CACHE request carries byte enables");

endmodule

`default_nettype wire

/* design/access_router.sv */
`timescale 1ns/1ps
`default_nettype none

module access_router (
    input  logic   Clk,
    input  logic   i_int_reset,
    mem_req_if.dst req,
    bus_cmd_if.src cmd
);

    logic                    is_load;
    logic                    is_store;
    logic                    is_cache;
    logic                    take;
    logic [2:0]              cache_sel;
    logic [1:0]              cache_target;
    memstage_pkg::cache_op_e cache_cmd;

    assign take         = req.valid & ~req.misaligned;
    assign cache_sel    = req.cache_code[4:2];
    assign cache_target = req.cache_code[1:0];

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_cache = 1'b0;
        case (req.op)
            memstage_pkg::OP_LB, memstage_pkg::OP_LH,
            memstage_pkg::OP_LW, memstage_pkg::OP_LL: is_load = 1'b1;
            memstage_pkg::OP_SB, memstage_pkg::OP_SH,
            memstage_pkg::OP_SW, memstage_pkg::OP_SC: is_store = 1'b1;
            memstage_pkg::OP_CACHE: is_cache = 1'b1;
            default: is_cache = 1'b0;
        endcase
    end

    // Anything not index invalidate or store tag is a hit writeback.
    always_comb begin
        if (cache_sel == memstage_pkg::CACHE_SEL_INDEX_INVALIDATE) begin
            cache_cmd = memstage_pkg::CACHE_INDEX_INVALIDATE;
        end else if (cache_sel == memstage_pkg::CACHE_SEL_STORE_TAG) begin
            cache_cmd = memstage_pkg::CACHE_STORE_TAG;
        end else begin
            cache_cmd = memstage_pkg::CACHE_HIT_WRITEBACK;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_int_reset) begin
            cmd.cached_rd   <= 1'b0;
            cmd.cached_wr   <= 1'b0;
            cmd.uncached_rd <= 1'b0;
            cmd.uncached_wr <= 1'b0;
            cmd.icache_op   <= memstage_pkg::CACHE_NONE;
            cmd.dcache_op   <= memstage_pkg::CACHE_NONE;
            cmd.addr_error  <= 1'b0;
        end else begin
            cmd.cached_rd   <= take & is_load & ~req.uncached;
            cmd.cached_wr   <= take & is_store & ~req.uncached;
            cmd.uncached_rd <= take & is_load & req.uncached;
            cmd.uncached_wr <= take & is_store & req.uncached;
            cmd.icache_op   <= (take && is_cache &&
                                cache_target == memstage_pkg::CACHE_TARGET_ICACHE)
                               ? cache_cmd : memstage_pkg::CACHE_NONE;
            cmd.dcache_op   <= (take && is_cache &&
                                cache_target == memstage_pkg::CACHE_TARGET_DCACHE)
                               ? cache_cmd : memstage_pkg::CACHE_NONE;
            cmd.addr_error  <= req.valid & req.misaligned;
        end
    end

    always_ff @(posedge Clk) begin
        cmd.addr   <= req.addr;
        cmd.byteen <= req.byteen;
        cmd.size   <= req.size;
        cmd.wdata  <= req.wdata;
    end

    a_one_port: assert property (
        @(posedge Clk) disable iff (i_int_reset)
        $onehot0({cmd.cached_rd, cmd.cached_wr, cmd.uncached_rd, cmd.uncached_wr})
    ) else $error("more than one access strobe active");

endmodule

`default_nettype wire

/* design/store_lane_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module store_lane_aligner (
    input  logic                    Clk,
    input  logic                    i_int_reset,
    bus_cmd_if.dst                  cmd,
    output logic                    o_dcache_read,
    output logic                    o_dcache_write,
    output logic                    o_dsram_read,
    output logic                    o_dsram_write,
    output memstage_pkg::cache_op_e o_icache_op,
    output memstage_pkg::cache_op_e o_dcache_op,
    output memstage_pkg::word_t     o_addr,
    output memstage_pkg::byteen_t   o_byteen,
    output memstage_pkg::size_e     o_size,
    output memstage_pkg::word_t     o_wdata,
    output logic                    o_addr_error
);

    logic                write;
    memstage_pkg::word_t wdata_lanes;

    assign write = cmd.cached_wr | cmd.uncached_wr;

    // Replicate narrow stores so every enabled lane sees the data.
    always_comb begin
        case (cmd.size)
            memstage_pkg::SIZE_BYTE: wdata_lanes = {4{cmd.wdata[7:0]}};
            memstage_pkg::SIZE_HALF: wdata_lanes = {2{cmd.wdata[15:0]}};
            default:                 wdata_lanes = cmd.wdata;
        endcase
        if (!write) begin
            wdata_lanes = memstage_pkg::WORD_ZERO;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_int_reset) begin
            o_dcache_read  <= 1'b0;
            o_dcache_write <= 1'b0;
            o_dsram_read   <= 1'b0;
            o_dsram_write  <= 1'b0;
            o_icache_op    <= memstage_pkg::CACHE_NONE;
            o_dcache_op    <= memstage_pkg::CACHE_NONE;
            o_addr_error   <= 1'b0;
        end else begin
            o_dcache_read  <= cmd.cached_rd;
            o_dcache_write <= cmd.cached_wr;
            o_dsram_read   <= cmd.uncached_rd;
            o_dsram_write  <= cmd.uncached_wr;
            o_icache_op    <= cmd.icache_op;
            o_dcache_op    <= cmd.dcache_op;
            o_addr_error   <= cmd.addr_error;
        end
    end

    always_ff @(posedge Clk) begin
        o_addr   <= cmd.addr;
        o_byteen <= cmd.byteen;
        o_size   <= cmd.size;
        o_wdata  <= wdata_lanes;
    end

endmodule

`default_nettype wire

/* design/memstage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memstage_top #(
    parameter int RESET_COUNT_WIDTH = 7
) (
    input  logic                      Clk,
    input  logic                      Myreset,
    input  logic                      i_valid,
    input  memstage_pkg::mem_op_e     i_op,
    input  memstage_pkg::word_t       i_addr,
    input  memstage_pkg::word_t       i_wdata,
    input  logic                      i_uncached,
    input  logic                      i_except,
    input  memstage_pkg::cache_code_t i_cache_code,
    output logic                      o_ready,
    output logic                      o_dcache_read,
    output logic                      o_dcache_write,
    output logic                      o_dsram_read,
    output logic                      o_dsram_write,
    output memstage_pkg::cache_op_e   o_icache_op,
    output memstage_pkg::cache_op_e   o_dcache_op,
    output memstage_pkg::word_t       o_addr,
    output memstage_pkg::byteen_t     o_byteen,
    output memstage_pkg::size_e       o_size,
    output memstage_pkg::word_t       o_wdata,
    output logic                      o_addr_error
);

    logic int_reset;

    mem_req_if req_if ();
    bus_cmd_if cmd_if ();

    reset_stretcher #(
        .RESET_COUNT_WIDTH(RESET_COUNT_WIDTH)
    ) u_reset_stretcher (
        .i_clk       (Clk),
        .i_myreset   (Myreset),
        .o_int_reset (int_reset),
        .o_ready     (o_ready)
    );

    // ========================================================================
    // Decode, route and align stages.
    // ========================================================================
    mem_op_decoder u_mem_op_decoder (
        .Clk          (Clk),
        .i_int_reset  (int_reset),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_uncached   (i_uncached),
        .i_except     (i_except),
        .i_cache_code (i_cache_code),
        .req          (req_if.src)
    );

    access_router u_access_router (
        .Clk         (Clk),
        .i_int_reset (int_reset),
        .req         (req_if.dst),
        .cmd         (cmd_if.src)
    );

    store_lane_aligner u_store_lane_aligner (
        .Clk            (Clk),
        .i_int_reset    (int_reset),
        .cmd            (cmd_if.dst),
        .o_dcache_read  (o_dcache_read),
        .o_dcache_write (o_dcache_write),
        .o_dsram_read   (o_dsram_read),
        .o_dsram_write  (o_dsram_write),
        .o_icache_op    (o_icache_op),
        .o_dcache_op    (o_dcache_op),
        .o_addr         (o_addr),
        .o_byteen       (o_byteen),
        .o_size         (o_size),
        .o_wdata        (o_wdata),
        .o_addr_error   (o_addr_error)
    );

endmodule

`default_nettype wire

/* testbench/memstage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memstage_tb;

    localparam int RESET_COUNT_WIDTH = 7;
    localparam int RESET_CYCLES      = 10;
    localparam int NUM_ROWS          = 29;
    localparam int TIMEOUT_CYCLES    = RESET_CYCLES + 2**RESET_COUNT_WIDTH + NUM_ROWS + 3 + 50;

    typedef struct packed {
        memstage_pkg::mem_op_e     op;
        memstage_pkg::word_t       addr;
        memstage_pkg::word_t       wdata;
        logic                      uncached;
        logic                      except;
        memstage_pkg::cache_code_t code;
        logic                      exp_dc_rd;
        logic                      exp_dc_wr;
        logic                      exp_ds_rd;
        logic                      exp_ds_wr;
        logic                      exp_err;
        memstage_pkg::cache_op_e   exp_iop;
        memstage_pkg::cache_op_e   exp_dop;
        memstage_pkg::byteen_t     exp_byteen;
        memstage_pkg::size_e       exp_size;
        memstage_pkg::word_t       exp_wdata;
        logic                      chk_data;
    } row_t;

    logic                      Clk;
    logic                      Myreset;
    logic                      i_valid;
    memstage_pkg::mem_op_e     i_op;
    memstage_pkg::word_t       i_addr;
    memstage_pkg::word_t       i_wdata;
    logic                      i_uncached;
    logic                      i_except;
    memstage_pkg::cache_code_t i_cache_code;
    logic                      o_ready;
    logic                      o_dcache_read;
    logic                      o_dcache_write;
    logic                      o_dsram_read;
    logic                      o_dsram_write;
    memstage_pkg::cache_op_e   o_icache_op;
    memstage_pkg::cache_op_e   o_dcache_op;
    memstage_pkg::word_t       o_addr;
    memstage_pkg::byteen_t     o_byteen;
    memstage_pkg::size_e       o_size;
    memstage_pkg::word_t       o_wdata;
    logic                      o_addr_error;

    row_t  rows [NUM_ROWS];
    int    row_count   = 0;
    int    cycle_count = 0;
    int    seed;
    string stage       = "reset";

    memstage_top #(
        .RESET_COUNT_WIDTH(RESET_COUNT_WIDTH)
    ) u_memstage_top (
        .Clk            (Clk),
        .Myreset        (Myreset),
        .i_valid        (i_valid),
        .i_op           (i_op),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_uncached     (i_uncached),
        .i_except       (i_except),
        .i_cache_code   (i_cache_code),
        .o_ready        (o_ready),
        .o_dcache_read  (o_dcache_read),
        .o_dcache_write (o_dcache_write),
        .o_dsram_read   (o_dsram_read),
        .o_dsram_write  (o_dsram_write),
        .o_icache_op    (o_icache_op),
        .o_dcache_op    (o_dcache_op),
        .o_addr         (o_addr),
        .o_byteen       (o_byteen),
        .o_size         (o_size),
        .o_wdata        (o_wdata),
        .o_addr_error   (o_addr_error)
    );

    initial begin
        Clk = 1'b0;
        forever #20 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the run hung and never finished checking the table.");
        end
    end

    // ========================================================================
    // Compare tasks.
    // ========================================================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s expected 0x%h actual 0x%h (%s)",
                                name, exp, act, stage));
        end
    endtask

    task automatic check_word(input string name, input memstage_pkg::word_t exp,
                              input memstage_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s expected 0x%h actual 0x%h (%s)",
                                name, exp, act, stage));
        end
    endtask

    task automatic check_byteen(input string name, input memstage_pkg::byteen_t exp,
                                input memstage_pkg::byteen_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s expected 0x%h actual 0x%h (%s)",
                                name, exp, act, stage));
        end
    endtask

    task automatic check_size(input string name, input memstage_pkg::size_e exp,
                              input memstage_pkg::size_e act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s expected 0x%h actual 0x%h (%s)",
                                name, exp, act, stage));
        end
    endtask

    task automatic check_cache_op(input string name, input memstage_pkg::cache_op_e exp,
                                  input memstage_pkg::cache_op_e act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s expected 0x%h actual 0x%h (%s)",
                                name, exp, act, stage));
        end
    endtask

    task automatic check_idle();
        check_bit("o_dcache_read", 1'b0, o_dcache_read);
        check_bit("o_dcache_write", 1'b0, o_dcache_write);
        check_bit("o_dsram_read", 1'b0, o_dsram_read);
        check_bit("o_dsram_write", 1'b0, o_dsram_write);
        check_bit("o_addr_error", 1'b0, o_addr_error);
        check_cache_op("o_icache_op", memstage_pkg::CACHE_NONE, o_icache_op);
        check_cache_op("o_dcache_op", memstage_pkg::CACHE_NONE, o_dcache_op);
    endtask

    task automatic check_row(input int idx);
        row_t r;
        r = rows[idx];
        stage = $sformatf("row %0d", idx);
        check_bit("o_ready", 1'b1, o_ready);
        check_bit("o_dcache_read", r.exp_dc_rd, o_dcache_read);
        check_bit("o_dcache_write", r.exp_dc_wr, o_dcache_write);
        check_bit("o_dsram_read", r.exp_ds_rd, o_dsram_read);
        check_bit("o_dsram_write", r.exp_ds_wr, o_dsram_write);
        check_bit("o_addr_error", r.exp_err, o_addr_error);
        check_cache_op("o_icache_op", r.exp_iop, o_icache_op);
        check_cache_op("o_dcache_op", r.exp_dop, o_dcache_op);
        check_word("o_wdata", r.exp_wdata, o_wdata);
        if (r.chk_data) begin
            check_word("o_addr", r.addr, o_addr);
            check_byteen("o_byteen", r.exp_byteen, o_byteen);
            check_size("o_size", r.exp_size, o_size);
        end
    endtask

    // ========================================================================
    // Stimulus table with expected values.
    // ========================================================================
    task automatic add_row(input memstage_pkg::mem_op_e op, input memstage_pkg::word_t addr,
                           input memstage_pkg::word_t wdata, input logic uncached,
                           input logic except, input memstage_pkg::cache_code_t code);
        row_t                    r;
        logic                    is_load;
        logic                    is_store;
        logic                    bad_align;
        memstage_pkg::cache_op_e cmd;
        r          = '0;
        r.op       = op;
        r.addr     = addr;
        r.wdata    = wdata;
        r.uncached = uncached;
        r.except   = except;
        r.code     = code;
        is_load    = op inside {memstage_pkg::OP_LB, memstage_pkg::OP_LH,
                                memstage_pkg::OP_LW, memstage_pkg::OP_LL};
        is_store   = op inside {memstage_pkg::OP_SB, memstage_pkg::OP_SH,
                                memstage_pkg::OP_SW, memstage_pkg::OP_SC};
        r.exp_size   = memstage_pkg::SIZE_WORD;
        r.exp_byteen = 4'b1111;
        r.exp_wdata  = wdata;
        bad_align    = (is_load || is_store) && (addr[1:0] != 2'b00);
        if (op == memstage_pkg::OP_LB || op == memstage_pkg::OP_SB) begin
            r.exp_size   = memstage_pkg::SIZE_BYTE;
            r.exp_byteen = (addr[1:0] == 2'd0) ? 4'b0001 : (addr[1:0] == 2'd1) ? 4'b0010 :
                           (addr[1:0] == 2'd2) ? 4'b0100 : 4'b1000;
            r.exp_wdata  = {wdata[7:0], wdata[7:0], wdata[7:0], wdata[7:0]};
            bad_align    = 1'b0;
        end else if (op == memstage_pkg::OP_LH || op == memstage_pkg::OP_SH) begin
            r.exp_size   = memstage_pkg::SIZE_HALF;
            r.exp_byteen = addr[1] ? 4'b1100 : 4'b0011;
            r.exp_wdata  = {wdata[15:0], wdata[15:0]};
            bad_align    = addr[0];
        end
        if (!(is_store && !bad_align && !except)) begin
            r.exp_wdata = 32'h0000_0000;
        end
        if (!except) begin
            r.exp_err   = bad_align;
            r.chk_data  = (is_load || is_store) && !bad_align;
            r.exp_dc_rd = r.chk_data && is_load && !uncached;
            r.exp_ds_rd = r.chk_data && is_load && uncached;
            r.exp_dc_wr = r.chk_data && is_store && !uncached;
            r.exp_ds_wr = r.chk_data && is_store && uncached;
            if (op == memstage_pkg::OP_CACHE) begin
                case (code[4:2])
                    3'b000:  cmd = memstage_pkg::CACHE_INDEX_INVALIDATE;
                    3'b010:  cmd = memstage_pkg::CACHE_STORE_TAG;
                    default: cmd = memstage_pkg::CACHE_HIT_WRITEBACK;
                endcase
                r.exp_iop = (code[1:0] == 2'b00) ? cmd : memstage_pkg::CACHE_NONE;
                r.exp_dop = (code[1:0] == 2'b01) ? cmd : memstage_pkg::CACHE_NONE;
            end
        end
        rows[row_count] = r;
        row_count       = row_count + 1;
    endtask

    task automatic build_table();
        // Aligned loads on both ports.
        add_row(memstage_pkg::OP_LB, $urandom, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LB, $urandom, $urandom, 1'b1, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LB, 32'h0000_1003, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LH, $urandom & 32'hffff_fffe, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LH, $urandom & 32'hffff_fffe, $urandom, 1'b1, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LW, $urandom & 32'hffff_fffc, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LL, $urandom & 32'hffff_fffc, $urandom, 1'b1, 1'b0, 5'b0);
        // Aligned stores.
        add_row(memstage_pkg::OP_SB, $urandom, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SB, $urandom, $urandom, 1'b1, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SB, 32'h0000_2001, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SH, $urandom & 32'hffff_fffe, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SH, 32'h0000_3002, $urandom, 1'b1, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SW, $urandom & 32'hffff_fffc, $urandom, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SC, $urandom & 32'hffff_fffc, $urandom, 1'b1, 1'b0, 5'b0);
        // Misaligned accesses followed by exception-killed ones.
        add_row(memstage_pkg::OP_LH, 32'h0000_1001, 32'h1111_2222, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SW, 32'h0000_2002, 32'h3333_4444, 1'b0, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LW, 32'h0000_3003, 32'h5555_6666, 1'b1, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_SH, 32'h0000_4003, 32'h7777_8888, 1'b1, 1'b0, 5'b0);
        add_row(memstage_pkg::OP_LW, 32'h0000_5000, 32'h9999_aaaa, 1'b0, 1'b1, 5'b0);
        add_row(memstage_pkg::OP_SB, 32'h0000_6001, 32'hbbbb_cccc, 1'b1, 1'b1, 5'b0);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_7000, 32'h0, 1'b0, 1'b1, 5'b000_01);
        // Maintenance commands.
        add_row(memstage_pkg::OP_CACHE, 32'h0000_8000, 32'h0, 1'b0, 1'b0, 5'b000_00);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_8040, 32'h0, 1'b0, 1'b0, 5'b000_01);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_8080, 32'h0, 1'b0, 1'b0, 5'b010_00);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_80c0, 32'h0, 1'b1, 1'b0, 5'b010_01);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_8100, 32'h0, 1'b0, 1'b0, 5'b101_00);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_8140, 32'h0, 1'b0, 1'b0, 5'b111_01);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_8180, 32'h0, 1'b0, 1'b0, 5'b000_10);
        add_row(memstage_pkg::OP_CACHE, 32'h0000_81c0, 32'h0, 1'b0, 1'b0, 5'b010_11);
    endtask

    task automatic drive_row(input row_t r);
        i_valid      = 1'b1;
        i_op         = r.op;
        i_addr       = r.addr;
        i_wdata      = r.wdata;
        i_uncached   = r.uncached;
        i_except     = r.except;
        i_cache_code = r.code;
    endtask

    task automatic drive_idle();
        i_valid      = 1'b0;
        i_op         = memstage_pkg::OP_LB;
        i_addr       = 32'h0000_0000;
        i_wdata      = 32'h0000_0000;
        i_uncached   = 1'b0;
        i_except     = 1'b0;
        i_cache_code = 5'b0;
    endtask

    // ========================================================================
    // Main sequence.
    // ========================================================================
    initial begin
        int   ready_cycles;
        logic ready_seen;
        seed         = 88;
        void'($urandom(seed));
        Myreset      = 1'b1;
        ready_cycles = 0;
        ready_seen   = 1'b0;
        drive_idle();
        build_table();
        if (row_count != NUM_ROWS) begin
            abort_run("The stimulus table does not hold the expected number of rows.");
        end
        repeat (RESET_CYCLES) @(negedge Clk);
        Myreset = 1'b0;

        // Strobes sent while the stretch is active must vanish.
        stage   = "reset stretch";
        i_valid = 1'b1;
        i_op    = memstage_pkg::OP_SW;
        i_addr  = 32'h0000_0100;
        i_wdata = 32'hdead_beef;
        while (!ready_seen) begin
            @(negedge Clk);
            ready_cycles = ready_cycles + 1;
            ready_seen   = o_ready;
            if (!ready_seen) begin
                check_idle();
            end
        end
        drive_idle();
        if (ready_cycles != 2**RESET_COUNT_WIDTH) begin
            abort_run($sformatf("o_ready rose %0d cycles after reset release, not %0d.",
                                ready_cycles, 2**RESET_COUNT_WIDTH));
        end
        stage = "after reset";
        repeat (4) begin
            @(negedge Clk);
            check_idle();
        end

        // Each row is checked three cycles after it is driven.
        for (int c = 0; c < NUM_ROWS + 3; c++) begin
            if (c >= 3) begin
                check_row(c - 3);
            end
            if (c < NUM_ROWS) begin
                drive_row(rows[c]);
            end else begin
                drive_idle();
            end
            @(negedge Clk);
        end
        stage = "drained";
        check_idle();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/memstage_pkg.sv
design/mem_req_if.sv
design/bus_cmd_if.sv
design/reset_stretcher.sv
design/mem_op_decoder.sv
design/access_router.sv
design/store_lane_aligner.sv
design/memstage_top.sv
testbench/memstage_tb.sv

/* Bender.yml */
package:
  name: memstage

sources:
  - design/memstage_pkg.sv
  - design/mem_req_if.sv
  - design/bus_cmd_if.sv
  - design/reset_stretcher.sv
  - design/mem_op_decoder.sv
  - design/access_router.sv
  - design/store_lane_aligner.sv
  - design/memstage_top.sv
  - target: test
    files:
      - testbench/memstage_tb.sv
